//--- cae_pers.f
logic/cae_dispatch_pkg.sv
logic/pe_array_pkg.sv
logic/cae_dispatch.sv
logic/pe_issue.sv
logic/spmv_pe.sv
logic/pe_collect.sv
logic/cae_pers.sv
verification/cae_pers_props.sv
verification/cae_pers_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module cae_pers_tb \
   -f cae_pers.f \
   -o sim_cae_pers

sim_out="$(./obj_dir/sim_cae_pers 2>&1 || true)"
echo "$sim_out"
grep -q "Verification passed" <<< "$sim_out"

//--- verification/cae_pers_tb.sv
`default_nettype none
`timescale 1ns/1ns

module cae_pers_tb
   import cae_dispatch_pkg::*;
   import pe_array_pkg::*;
();

   localparam int IDLE_TIMEOUT = 50;

   logic clk;
   logic r_reset;
   logic [INST_W-1:0] cae_inst_i;
   logic [WORD_W-1:0] cae_data_i;
   logic cae_inst_vld_i;
   logic [AEG_IDX_W-1:0] cae_aeg_cnt_o;
   logic [EXC_W-1:0] cae_exception_o;
   logic [WORD_W-1:0] cae_ret_data_o;
   logic cae_ret_data_vld_o;
   logic cae_idle_o;
   logic cae_stall_o;

   // reference state
   logic [PAYLOAD_W-1:0] model_acc [N_PE];
   logic [WORD_W-1:0] model_aeg0;
   logic [WORD_W-1:0] model_aeg1;
   logic [WORD_W-1:0] exp_q [$];
   logic [WORD_W-1:0] exp_word;

   cae_pers i_cae_pers (
      .clk                (clk),
      .r_reset            (r_reset),
      .cae_inst_i         (cae_inst_i),
      .cae_data_i         (cae_data_i),
      .cae_inst_vld_i     (cae_inst_vld_i),
      .cae_aeg_cnt_o      (cae_aeg_cnt_o),
      .cae_exception_o    (cae_exception_o),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o),
      .cae_idle_o         (cae_idle_o),
      .cae_stall_o        (cae_stall_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      if (got !== want) begin
         stop_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want));
      end
   endtask

   function automatic logic [INST_W-1:0] custom_inst(input logic [CAEP_W-1:0] num);
      return {KIND_CUSTOM, 25'd0, num};
   endfunction

   function automatic logic [INST_W-1:0] aeg_inst(input logic [1:0] kind,
                                                  input logic [AEG_IDX_W-1:0] idx);
      return {kind, 12'd0, idx};
   endfunction

   function automatic logic [WORD_W-1:0] chain_word(input logic [7:0] opc, input logic [7:0] idx,
                                                    input logic [47:0] pay);
      return {opc, idx, pay};
   endfunction

   function automatic logic [47:0] rand48();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[47:0];
   endfunction

   // one chain word through the model, returns AEG0 after it drains
   function automatic logic [WORD_W-1:0] model_step(input logic [WORD_W-1:0] w);
      logic [7:0] opc;
      logic [7:0] idx;
      logic [47:0] total;
      opc = w[63:56];
      idx = w[55:48];
      total = w[47:0];
      if (idx < 8'(N_PE)) begin
         if (opc == OP_SET) begin
            model_acc[idx[1:0]] = w[47:0];
         end else if (opc == OP_ADD) begin
            model_acc[idx[1:0]] = model_acc[idx[1:0]] + w[47:0];
         end
      end
      if (opc != OP_SUM) begin
         return model_aeg0;
      end
      for (int k = 0; k < N_PE; k++) begin
         total = total + model_acc[k];
      end
      return {OP_RETURN, idx, total};
   endfunction

   // one instruction for one cycle
   task automatic send(input logic [INST_W-1:0] inst, input logic [WORD_W-1:0] data);
      cae_inst_i <= inst;
      cae_data_i <= data;
      cae_inst_vld_i <= 1'b1;
      @(posedge clk);
      cae_inst_vld_i <= 1'b0;
   endtask

   task automatic aeg_write(input logic [AEG_IDX_W-1:0] idx, input logic [WORD_W-1:0] data);
      send(aeg_inst(KIND_AEG_WR, idx), data);
      if (idx == 0) begin
         model_aeg0 = data;
      end else if (idx == 1) begin
         model_aeg1 = data;
      end
   endtask

   task automatic aeg_read(input logic [AEG_IDX_W-1:0] idx);
      exp_q.push_back((idx == 0) ? model_aeg0 : model_aeg1);
      send(aeg_inst(KIND_AEG_RD, idx), 64'd0);
      @(negedge clk);
      check_value("cae_ret_data_vld_o", 64'(cae_ret_data_vld_o), 64'd1);
      @(posedge clk);
   endtask

   task automatic expect_exception(input logic [INST_W-1:0] inst, input logic [EXC_W-1:0] want);
      send(inst, 64'd0);
      @(negedge clk);
      check_value("cae_exception_o", 64'(cae_exception_o), 64'(want));
      check_value("cae_ret_data_vld_o", 64'(cae_ret_data_vld_o), 64'd0);
      // gone again one cycle later
      @(negedge clk);
      check_value("cae_exception_o", 64'(cae_exception_o), 64'd0);
      @(posedge clk);
   endtask

   task automatic launch_word(input logic [WORD_W-1:0] w);
      aeg_write(0, w);
      send(custom_inst(CAEP_LAUNCH), 64'd0);
      model_aeg0 = model_step(w);
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!cae_idle_o) begin
         cycles++;
         if (cycles > IDLE_TIMEOUT) begin
            stop_run("timeout while waiting for the core to go idle");
         end
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   // stall should cover the launch cycle, issue, every pe and the collector
   task automatic measure_launch(input logic [WORD_W-1:0] w);
      int cycles;
      aeg_write(0, w);
      cae_inst_i <= custom_inst(CAEP_LAUNCH);
      cae_inst_vld_i <= 1'b1;
      model_aeg0 = model_step(w);
      @(negedge clk);
      check_value("cae_stall_o", 64'(cae_stall_o), 64'd1);
      @(posedge clk);
      cae_inst_vld_i <= 1'b0;
      cycles = 1;
      @(negedge clk);
      while (cae_stall_o) begin
         cycles++;
         if (cycles > IDLE_TIMEOUT) begin
            stop_run("stall did not return low after a launch");
         end
         @(negedge clk);
      end
      check_value("stall_cycles", 64'(cycles), 64'(N_PE + 3));
      @(posedge clk);
   endtask

   // every read return against the queued expectation
   always @(negedge clk) begin
      if (!r_reset && cae_ret_data_vld_o) begin
         if (exp_q.size() == 0) begin
            stop_run("read data returned with no read pending");
         end else begin
            exp_word = exp_q.pop_front();
            check_value("cae_ret_data_o", cae_ret_data_o, exp_word);
         end
      end
   end

   initial begin
      void'($urandom(20));
      r_reset = 1'b1;
      cae_inst_i = '0;
      cae_data_i = '0;
      cae_inst_vld_i = 1'b0;
      model_aeg0 = '0;
      model_aeg1 = '0;
      for (int k = 0; k < N_PE; k++) begin
         model_acc[k] = '0;
      end
      repeat (16) @(posedge clk);
      r_reset <= 1'b0;
      @(negedge clk);
      check_value("cae_idle_o", 64'(cae_idle_o), 64'd1);
      check_value("cae_stall_o", 64'(cae_stall_o), 64'd0);
      check_value("cae_aeg_cnt_o", 64'(cae_aeg_cnt_o), 64'd2);
      check_value("cae_exception_o", 64'(cae_exception_o), 64'd0);
      @(posedge clk);

      aeg_read(0);
      aeg_read(1);
      aeg_write(1, {$urandom(), $urandom()});
      aeg_read(1);

      expect_exception(aeg_inst(KIND_AEG_RD, 18'd2), 16'd1 << EXC_AEGIDX);
      expect_exception(aeg_inst(KIND_AEG_WR, 18'd3), 16'd1 << EXC_AEGIDX);
      expect_exception({KIND_UNIMPL, 30'd0}, 16'd1 << EXC_UNIMPL);
      expect_exception(custom_inst(5'd5), 16'd1 << EXC_UNIMPL);
      expect_exception(custom_inst(CAEP_HELLO), 16'd0);
      expect_exception(custom_inst(CAEP_NOP), 16'd0);
      aeg_read(1);

      // load every pe, then sum
      for (int i = 0; i < N_PE; i++) begin
         launch_word(chain_word(OP_SET, 8'(i), rand48()));
         wait_idle();
      end
      launch_word(chain_word(OP_SUM, 8'($urandom()), rand48()));
      wait_idle();
      aeg_read(0);

      // random updates, indices past the last pe included
      repeat (12) begin
         repeat (1 + $urandom_range(0, 3)) begin
            launch_word(chain_word(($urandom_range(0, 1) == 0) ? OP_ADD : OP_SET,
                                   8'($urandom_range(0, 5)), rand48()));
            wait_idle();
         end
         launch_word(chain_word(OP_SUM, 8'($urandom()), rand48()));
         wait_idle();
         aeg_read(0);
      end

      measure_launch(chain_word(OP_SUM, 8'd7, rand48()));
      aeg_read(0);

      // two sums in flight together, the later one lands last
      launch_word(chain_word(OP_SUM, 8'd1, rand48()));
      launch_word(chain_word(OP_SUM, 8'd2, rand48()));
      wait_idle();
      aeg_read(0);
      aeg_read(1);

      @(posedge clk);
      @(negedge clk);
      if (exp_q.size() != 0) begin
         stop_run("expected read data never returned");
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- verification/cae_pers_props.sv
`default_nettype none
`timescale 1ns/1ns

module cae_pers_props
   import cae_dispatch_pkg::*;
(
   input logic clk,
   input logic r_reset,
   input logic [INST_W-1:0] cae_inst_i,
   input logic cae_inst_vld_i,
   input logic [EXC_W-1:0] cae_exception_o,
   input logic cae_idle_o,
   input logic cae_stall_o
);

   logic rd_in_range;
   logic launch_seen;

   assign rd_in_range = cae_inst_vld_i && (cae_inst_i[KIND_MSB:KIND_LSB] == KIND_AEG_RD) &&
                        (cae_inst_i[AEG_IDX_W-1:0] < AEG_IDX_W'(NUM_AEG));
   assign launch_seen = cae_inst_vld_i && (cae_inst_i[KIND_MSB:KIND_LSB] == KIND_CUSTOM) &&
                        (cae_inst_i[CAEP_W-1:0] == CAEP_LAUNCH);

   idle_is_not_stall: assert property (@(posedge clk) disable iff (r_reset)
      cae_idle_o == !cae_stall_o)
      else $error("idle is not the inverse of stall");

   good_read_no_exc: assert property (@(posedge clk) disable iff (r_reset)
      rd_in_range |=> (cae_exception_o == EXC_W'(0)))
      else $error("exception raised after an in-range AEG read");

   launch_stalls: assert property (@(posedge clk) disable iff (r_reset)
      launch_seen |-> cae_stall_o)
      else $error("stall low in a launch cycle");

endmodule

bind cae_pers cae_pers_props i_props (
   .clk             (clk),
   .r_reset         (r_reset),
   .cae_inst_i      (cae_inst_i),
   .cae_inst_vld_i  (cae_inst_vld_i),
   .cae_exception_o (cae_exception_o),
   .cae_idle_o      (cae_idle_o),
   .cae_stall_o     (cae_stall_o)
);

`default_nettype wire

//--- logic/cae_pers.sv
`default_nettype none
`timescale 1ns/1ns

module cae_pers
   import cae_dispatch_pkg::*;
   import pe_array_pkg::*;
(
   input  logic clk,
   input  logic r_reset,

   // dispatch interface
   input  logic [INST_W-1:0] cae_inst_i,
   input  logic [WORD_W-1:0] cae_data_i,
   input  logic cae_inst_vld_i,
   output logic [AEG_IDX_W-1:0] cae_aeg_cnt_o,
   output logic [EXC_W-1:0] cae_exception_o,
   output logic [WORD_W-1:0] cae_ret_data_o,
   output logic cae_ret_data_vld_o,
   output logic cae_idle_o,
   output logic cae_stall_o
);

   logic launch;
   pe_word_t aeg0;
   logic drain;
   logic wb_vld;
   pe_word_t wb_word;

   // stage k feeds pe k, last entry goes to the collector
   logic [N_PE:0] chain_vld;
   pe_word_t [N_PE:0] chain_word;

   cae_dispatch i_dispatch (
      .clk                (clk),
      .r_reset            (r_reset),
      .cae_inst_i         (cae_inst_i),
      .cae_data_i         (cae_data_i),
      .cae_inst_vld_i     (cae_inst_vld_i),
      .cae_aeg_cnt_o      (cae_aeg_cnt_o),
      .cae_exception_o    (cae_exception_o),
      .cae_ret_data_o     (cae_ret_data_o),
      .cae_ret_data_vld_o (cae_ret_data_vld_o),
      .wb_vld_i           (wb_vld),
      .wb_word_i          (wb_word),
      .launch_o           (launch),
      .aeg0_o             (aeg0)
   );

   pe_issue i_issue (
      .clk          (clk),
      .r_reset      (r_reset),
      .launch_i     (launch),
      .aeg0_i       (aeg0),
      .drain_i      (drain),
      .issue_vld_o  (chain_vld[0]),
      .issue_word_o (chain_word[0]),
      .cae_stall_o  (cae_stall_o),
      .cae_idle_o   (cae_idle_o)
   );

   for (genvar g = 0; g < N_PE; g++) begin : g_pe
      spmv_pe #(
         .PE_IDX (g)
      ) i_pe (
         .clk     (clk),
         .r_reset (r_reset),
         .vld_i   (chain_vld[g]),
         .word_i  (chain_word[g]),
         .vld_o   (chain_vld[g+1]),
         .word_o  (chain_word[g+1])
      );
   end

   pe_collect i_collect (
      .clk       (clk),
      .r_reset   (r_reset),
      .vld_i     (chain_vld[N_PE]),
      .word_i    (chain_word[N_PE]),
      .drain_o   (drain),
      .wb_vld_o  (wb_vld),
      .wb_word_o (wb_word)
   );

endmodule

`default_nettype wire

//--- logic/pe_collect.sv
`default_nettype none
`timescale 1ns/1ns

module pe_collect
   import pe_array_pkg::*;
(
   input  logic clk,
   input  logic r_reset,
   input  logic vld_i,
   input  pe_word_t word_i,
   output logic drain_o,
   output logic wb_vld_o,
   output pe_word_t wb_word_o
);

   logic is_sum;
   pe_word_t ret_word;

   assign is_sum = (word_i.f.opcode == OP_SUM);

   // finished sum comes back tagged as a return
   always_comb begin
      ret_word = word_i;
      if (is_sum) begin
         ret_word.f.opcode = OP_RETURN;
      end
   end

   always_ff @(posedge clk) begin
      if (r_reset) begin
         drain_o <= 1'b0;
         wb_vld_o <= 1'b0;
      end else begin
         drain_o <= vld_i;
         wb_vld_o <= vld_i && is_sum;
      end
   end

   always_ff @(posedge clk) begin
      if (vld_i) begin
         wb_word_o <= ret_word;
      end
   end

endmodule

`default_nettype wire

//--- logic/spmv_pe.sv
`default_nettype none
`timescale 1ns/1ns

module spmv_pe
   import pe_array_pkg::*;
#(
   parameter int PE_IDX = 0
) (
   input  logic clk,
   input  logic r_reset,
   input  logic vld_i,
   input  pe_word_t word_i,
   output logic vld_o,
   output pe_word_t word_o
);

   logic [PAYLOAD_W-1:0] acc_q;
   logic hit;
   pe_word_t word_d;

   assign hit = (word_i.f.pe_idx == PE_IDX_W'(PE_IDX));

   // accumulator, only words addressed to this pe
   always_ff @(posedge clk) begin
      if (r_reset) begin
         acc_q <= '0;
      end else if (vld_i && hit) begin
         case (word_i.f.opcode)
            OP_SET: begin
               acc_q <= word_i.f.payload;
            end
            OP_ADD: begin
               acc_q <= acc_q + word_i.f.payload;
            end
            default: begin
               acc_q <= acc_q;
            end
         endcase
      end
   end

   // sum picks up every accumulator on its way down
   always_comb begin
      word_d = word_i;
      if (word_i.f.opcode == OP_SUM) begin
         word_d.f.payload = word_i.f.payload + acc_q;
      end
   end

   always_ff @(posedge clk) begin
      if (r_reset) begin
         vld_o <= 1'b0;
      end else begin
         vld_o <= vld_i;
      end
   end

   always_ff @(posedge clk) begin
      if (vld_i) begin
         word_o <= word_d;
      end
   end

endmodule

`default_nettype wire

//--- logic/pe_issue.sv
`default_nettype none
`timescale 1ns/1ns

module pe_issue
   import pe_array_pkg::*;
(
   input  logic clk,
   input  logic r_reset,
   input  logic launch_i,
   input  pe_word_t aeg0_i,
   input  logic drain_i,
   output logic issue_vld_o,
   output pe_word_t issue_word_o,
   output logic cae_stall_o,
   output logic cae_idle_o
);

   logic [INFLIGHT_W-1:0] inflight_q;

   // head of the chain
   always_ff @(posedge clk) begin
      if (r_reset) begin
         issue_vld_o <= 1'b0;
      end else begin
         issue_vld_o <= launch_i;
      end
   end

   always_ff @(posedge clk) begin
      if (launch_i) begin
         issue_word_o <= aeg0_i;
      end
   end

   // words between launch and drain
   always_ff @(posedge clk) begin
      if (r_reset) begin
         inflight_q <= '0;
      end else if (launch_i && !drain_i) begin
         inflight_q <= inflight_q + 1'b1;
      end else if (drain_i && !launch_i) begin
         inflight_q <= inflight_q - 1'b1;
      end
   end

   // busy from the launch cycle on
   assign cae_stall_o = launch_i || (inflight_q != '0);
   assign cae_idle_o = !cae_stall_o;

endmodule

`default_nettype wire

//--- logic/cae_dispatch.sv
`default_nettype none
`timescale 1ns/1ns

module cae_dispatch
   import cae_dispatch_pkg::*;
   import pe_array_pkg::*;
(
   input  logic clk,
   input  logic r_reset,

   // host dispatch
   input  logic [INST_W-1:0] cae_inst_i,
   input  logic [WORD_W-1:0] cae_data_i,
   input  logic cae_inst_vld_i,
   output logic [AEG_IDX_W-1:0] cae_aeg_cnt_o,
   output logic [EXC_W-1:0] cae_exception_o,
   output logic [WORD_W-1:0] cae_ret_data_o,
   output logic cae_ret_data_vld_o,

   // result from the collector
   input  logic wb_vld_i,
   input  pe_word_t wb_word_i,

   // to the issue stage
   output logic launch_o,
   output pe_word_t aeg0_o
);

   logic [1:0] inst_kind;
   logic [CAEP_W-1:0] inst_caep;
   logic [AEG_IDX_W-1:0] inst_aeg_idx;
   logic is_custom;
   logic is_aeg_wr;
   logic is_aeg_rd;
   logic idx_ok;
   logic caep_known;
   logic [NUM_AEG-1:0] aeg_we;

   pe_word_t aeg_q [NUM_AEG];

   logic ret_vld_q;
   logic [WORD_W-1:0] ret_data_q;
   logic exc_unimpl_q;
   logic exc_aegidx_q;

   // field decode
   assign inst_kind = cae_inst_i[KIND_MSB:KIND_LSB];
   assign inst_caep = cae_inst_i[CAEP_W-1:0];
   assign inst_aeg_idx = cae_inst_i[AEG_IDX_W-1:0];

   assign is_custom = cae_inst_vld_i && (inst_kind == KIND_CUSTOM);
   assign is_aeg_wr = cae_inst_vld_i && (inst_kind == KIND_AEG_WR);
   assign is_aeg_rd = cae_inst_vld_i && (inst_kind == KIND_AEG_RD);
   assign idx_ok = inst_aeg_idx < AEG_IDX_W'(NUM_AEG);

   assign caep_known = (inst_caep == CAEP_HELLO) ||
                       (inst_caep == CAEP_LAUNCH) ||
                       (inst_caep == CAEP_NOP);

   assign launch_o = is_custom && (inst_caep == CAEP_LAUNCH);

   always_comb begin
      for (int i = 0; i < NUM_AEG; i++) begin
         aeg_we[i] = is_aeg_wr && (inst_aeg_idx == AEG_IDX_W'(i));
      end
   end

   // aeg registers
   always_ff @(posedge clk) begin
      if (r_reset) begin
         for (int i = 0; i < NUM_AEG; i++) begin
            aeg_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_AEG; i++) begin
            if (aeg_we[i]) begin
               aeg_q[i].raw <= cae_data_i;
            end
         end
         // host write to aeg0 wins over the write-back
         if (wb_vld_i && !aeg_we[0]) begin
            aeg_q[0] <= wb_word_i;
         end
      end
   end

   assign aeg0_o = aeg_q[0];
   assign cae_aeg_cnt_o = AEG_IDX_W'(NUM_AEG);

   // read return, one cycle after the request
   always_ff @(posedge clk) begin
      if (r_reset) begin
         ret_vld_q <= 1'b0;
      end else begin
         ret_vld_q <= is_aeg_rd && idx_ok;
      end
   end

   always_ff @(posedge clk) begin
      if (is_aeg_rd) begin
         ret_data_q <= aeg_q[inst_aeg_idx[AEG_SEL_W-1:0]].raw;
      end
   end

   assign cae_ret_data_vld_o = ret_vld_q;
   assign cae_ret_data_o = ret_data_q;

   // exceptions last one cycle
   always_ff @(posedge clk) begin
      if (r_reset) begin
         exc_unimpl_q <= 1'b0;
         exc_aegidx_q <= 1'b0;
      end else begin
         exc_unimpl_q <= (cae_inst_vld_i && (inst_kind == KIND_UNIMPL)) ||
                         (is_custom && !caep_known);
         exc_aegidx_q <= (is_aeg_wr || is_aeg_rd) && !idx_ok;
      end
   end

   always_comb begin
      cae_exception_o = '0;
      cae_exception_o[EXC_UNIMPL] = exc_unimpl_q;
      cae_exception_o[EXC_AEGIDX] = exc_aegidx_q;
   end

endmodule

`default_nettype wire

//--- logic/pe_array_pkg.sv
`default_nettype none

package pe_array_pkg;

   localparam int WORD_W = 64;
   localparam int OPC_W = 8;
   localparam int PE_IDX_W = 8;
   localparam int PAYLOAD_W = 48;
   localparam int N_PE = 4;

   // words in flight from issue to collect, at most N_PE + 2
   localparam int INFLIGHT_W = $clog2(N_PE + 3);

   // chain opcodes
   localparam logic [OPC_W-1:0] OP_NOP = 8'd0;
   localparam logic [OPC_W-1:0] OP_SET = 8'd1;
   localparam logic [OPC_W-1:0] OP_ADD = 8'd2;
   localparam logic [OPC_W-1:0] OP_SUM = 8'd3;
   localparam logic [OPC_W-1:0] OP_RETURN = 8'd4;

   typedef struct packed {
      logic [OPC_W-1:0] opcode;
      logic [PE_IDX_W-1:0] pe_idx;
      logic [PAYLOAD_W-1:0] payload;
   } pe_fields_t;

   // same 64 bits seen as an AEG value or as decoded fields
   typedef union packed {
      logic [WORD_W-1:0] raw;
      pe_fields_t f;
   } pe_word_t;

endpackage

`default_nettype wire

//--- logic/cae_dispatch_pkg.sv
`default_nettype none

package cae_dispatch_pkg;

   // instruction word layout
   localparam int INST_W = 32;
   localparam int KIND_MSB = 31;
   localparam int KIND_LSB = 30;

   // instruction kinds in bits 31:30
   localparam logic [1:0] KIND_CUSTOM = 2'd0;
   localparam logic [1:0] KIND_AEG_WR = 2'd1;
   localparam logic [1:0] KIND_AEG_RD = 2'd2;
   localparam logic [1:0] KIND_UNIMPL = 2'd3;

   // custom instruction numbers
   localparam int CAEP_W = 5;
   localparam logic [CAEP_W-1:0] CAEP_HELLO = 5'd0;
   localparam logic [CAEP_W-1:0] CAEP_LAUNCH = 5'd1;
   localparam logic [CAEP_W-1:0] CAEP_NOP = 5'd2;

   // application engine registers
   localparam int AEG_IDX_W = 18;
   localparam int NUM_AEG = 2;
   localparam int AEG_SEL_W = $clog2(NUM_AEG);

   // exception word
   localparam int EXC_W = 16;
   localparam int EXC_UNIMPL = 0;
   localparam int EXC_AEGIDX = 1;

endpackage

`default_nettype wire
